// ==== Bender.yml ====
package:
  name: zx_host_core

sources:
  - hw/zx_bus_pkg.sv
  - hw/zx_mem_pkg.sv
  - hw/zx_port_decode.sv
  - hw/zx_paging.sv
  - hw/zx_sound_ports.sv
  - hw/zx_mem_map.sv
  - hw/zx_host_core.sv
  - target: test
    files:
      - test/zx_checker.sv
      - test/tb_zx_host_core.sv

// ==== hw/zx_bus_pkg.sv ====
// ========================================
// Z80 bus side definitions
// ========================================
package zx_bus_pkg;

	localparam int addr_w  = 16;
	localparam int data_w  = 8;
	localparam int audio_w = 14;   // One mixed channel

	// Port write operations, one per decoded register
	typedef enum logic [3:0] {
		op_none,
		op_page_7ffd,   // 128K paging
		op_page_1ffd,   // +3 paging
		op_page_eff7,   // Pentagon 1024 config
		op_page_dffd,   // Profi high bank
		op_ula_fe,      // Border, ear, mic
		op_covox,
		op_sdrv_a,
		op_sdrv_b,
		op_sdrv_c,
		op_sdrv_d
	} port_op_t;

	// Sound ports decode on the low address byte only
	localparam logic [7:0] port_covox  = 8'hFB;
	localparam logic [7:0] port_sdrv_a = 8'h0F;
	localparam logic [7:0] port_sdrv_b = 8'h1F;
	localparam logic [7:0] port_sdrv_c = 8'h4F;
	localparam logic [7:0] port_sdrv_d = 8'h5F;

	// Full 16-bit match
	localparam logic [addr_w-1:0] port_profi = 16'hDFFD;

endpackage

// ==== hw/zx_host_core.sv ====
module zx_host_core (
	input  logic                              clk_sys,
	input  logic                              reset,
	input  zx_mem_pkg::arch_t                 mem_mode,
	input  logic [zx_bus_pkg::addr_w-1:0]     addr,
	input  logic [zx_bus_pkg::data_w-1:0]     data,
	input  logic                              n_mreq,
	input  logic                              n_iorq,
	input  logic                              n_rd,
	input  logic                              n_wr,
	input  logic                              n_m1,
	output logic [zx_mem_pkg::ram_addr_w-1:0] ram_addr,
	output logic                              ram_we,
	output logic [2:0]                        border,
	output logic                              ear,
	output logic                              mic,
	output logic [zx_bus_pkg::audio_w-1:0]    audio_l,
	output logic [zx_bus_pkg::audio_w-1:0]    audio_r
);

	zx_bus_pkg::port_op_t                port_op;
	logic                                port_wr;
	zx_mem_pkg::arch_t                   arch;
	logic                                page_lock;
	logic [zx_mem_pkg::page_w-1:0]       page_ram;
	logic [zx_mem_pkg::rom_page_w-1:0]   page_rom;
	logic                                page_special;
	logic [1:0]                          plus3_cfg;

	// ========================================
	// Decode
	zx_port_decode zx_port_decode_i (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.addr      (addr),
		.n_iorq    (n_iorq),
		.n_wr      (n_wr),
		.n_m1      (n_m1),
		.arch      (arch),        // Mode and lock fed back from paging
		.page_lock (page_lock),
		.port_op   (port_op),
		.port_wr   (port_wr)
	);

	// Execute
	zx_paging zx_paging_i (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.mem_mode     (mem_mode),
		.port_op      (port_op),
		.port_wr      (port_wr),
		.data         (data),
		.arch         (arch),
		.page_lock    (page_lock),
		.page_ram     (page_ram),
		.page_rom     (page_rom),
		.page_special (page_special),
		.plus3_cfg    (plus3_cfg)
	);

	zx_sound_ports zx_sound_ports_i (
		.clk_sys (clk_sys),
		.reset   (reset),
		.port_op (port_op),
		.port_wr (port_wr),
		.data    (data),
		.border  (border),
		.ear     (ear),
		.mic     (mic),
		.audio_l (audio_l),
		.audio_r (audio_r)
	);

	// Result
	zx_mem_map zx_mem_map_i (
		.addr         (addr),
		.n_mreq       (n_mreq),
		.n_wr         (n_wr),
		.page_ram     (page_ram),
		.page_rom     (page_rom),
		.page_special (page_special),
		.plus3_cfg    (plus3_cfg),
		.ram_addr     (ram_addr),
		.ram_we       (ram_we)
	);

	// Z80 never reads and writes in the same cycle
	bus_rd_wr_excl: assert property (@(posedge clk_sys) disable iff (reset)
		!(!n_rd && !n_wr));

endmodule

// ==== hw/zx_mem_map.sv ====
module zx_mem_map (
	input  logic [zx_bus_pkg::addr_w-1:0]     addr,
	input  logic                              n_mreq,
	input  logic                              n_wr,
	input  logic [zx_mem_pkg::page_w-1:0]     page_ram,
	input  logic [zx_mem_pkg::rom_page_w-1:0] page_rom,
	input  logic                              page_special,
	input  logic [1:0]                        plus3_cfg,
	output logic [zx_mem_pkg::ram_addr_w-1:0] ram_addr,
	output logic                              ram_we
);

	localparam int bank_w = zx_mem_pkg::bank_w;
	localparam int win_w  = zx_mem_pkg::win_w;

	logic [1:0]        win;       // 16K window of the Z80 map
	logic [2:0]        sp_bank;   // All-RAM bank
	logic [bank_w-1:0] bank_sel;

	assign win = addr[15:14];

	// +3 special modes
	always_comb begin
		case (plus3_cfg)
			2'd0:    sp_bank = {1'b0, win};   // 0 1 2 3
			2'd1:    sp_bank = {1'b1, win};   // 4 5 6 7
			2'd2:    sp_bank = (win == 2'd3) ? 3'd3 : {1'b1, win};   // 4 5 6 3
			default: begin
				case (win)   // 4 7 6 3
					2'd0:    sp_bank = 3'd4;
					2'd1:    sp_bank = 3'd7;
					2'd2:    sp_bank = 3'd6;
					default: sp_bank = 3'd3;
				endcase
			end
		endcase
	end

	// ========================================
	// Bank number above the window offset
	always_comb begin
		if (page_special) begin
			bank_sel = {{(bank_w - 3){1'b0}}, sp_bank};
		end else begin
			case (win)
				2'd0: bank_sel = {{(bank_w - 3 - zx_mem_pkg::rom_page_w){1'b0}},
					zx_mem_pkg::rom_region, page_rom};
				2'd1: bank_sel = {{(bank_w - 3){1'b0}}, zx_mem_pkg::bank_screen};
				2'd2: bank_sel = {{(bank_w - 3){1'b0}}, zx_mem_pkg::bank_mid};
				default: bank_sel = {{(bank_w - zx_mem_pkg::page_w){1'b0}}, page_ram};
			endcase
		end
	end

	assign ram_addr = {bank_sel, addr[win_w-1:0]};

	// ROM window is read only unless special mode maps RAM there
	assign ram_we = ~n_mreq & ~n_wr & ((win != 2'd0) | page_special);

	// No write may land in the ROM image
	rom_write_guard: assert final (!ram_we ||
		ram_addr[win_w + zx_mem_pkg::rom_page_w +: 3] != zx_mem_pkg::rom_region)
		else $error("SDRAM write into ROM region at %h", ram_addr);

endmodule

// ==== hw/zx_mem_pkg.sv ====
// ========================================
// Memory architecture and SDRAM layout
// ========================================
package zx_mem_pkg;

	// Codes follow the mode selector order
	typedef enum logic [2:0] {
		arch_128    = 3'd0,
		arch_p1024  = 3'd1,
		arch_pf1024 = 3'd2,
		arch_48     = 3'd3,
		arch_plus3  = 3'd4
	} arch_t;

	localparam int ram_addr_w = 24;   // SDRAM byte address
	localparam int page_w     = 6;    // Up to 64 RAM banks of 16K
	localparam int rom_page_w = 4;

	// Offset inside one 16K window
	localparam int win_w = 14;

	// Bank number field above the window offset
	localparam int bank_w = ram_addr_w - win_w;

	// ROM pages live behind this prefix
	localparam logic [2:0] rom_region = 3'b101;

	// Fixed banks of the 4000 and 8000 windows
	localparam logic [2:0] bank_screen = 3'd5;
	localparam logic [2:0] bank_mid    = 3'd2;

endpackage

// ==== hw/zx_paging.sv ====
module zx_paging (
	input  logic                               clk_sys,
	input  logic                               reset,
	input  zx_mem_pkg::arch_t                  mem_mode,
	input  zx_bus_pkg::port_op_t               port_op,
	input  logic                               port_wr,
	input  logic [zx_bus_pkg::data_w-1:0]      data,
	output zx_mem_pkg::arch_t                  arch,
	output logic                               page_lock,
	output logic [zx_mem_pkg::page_w-1:0]      page_ram,
	output logic [zx_mem_pkg::rom_page_w-1:0]  page_rom,
	output logic                               page_special,
	output logic [1:0]                         plus3_cfg
);

	// 7FFD fields
	logic [2:0] bank_7ffd;
	logic       rom_7ffd;
	logic       lock_7ffd;

	// 1FFD fields
	logic       special_1ffd;
	logic [1:0] cfg_1ffd;   // Bits 2..1

	logic       ext_eff7;   // EFF7 bit 2, back to plain 128K behaviour
	logic [2:0] page_128k;  // High bank bits of the 1024K machines

	logic is_48;
	logic is_plus3;
	logic is_p1024;

	assign is_48    = (arch == zx_mem_pkg::arch_48);
	assign is_plus3 = (arch == zx_mem_pkg::arch_plus3);
	assign is_p1024 = (arch == zx_mem_pkg::arch_p1024);

	// ========================================
	// Register file
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			arch         <= mem_mode;   // Follows the mode switch during reset
			bank_7ffd    <= 3'd0;
			rom_7ffd     <= 1'b0;
			lock_7ffd    <= 1'b0;
			special_1ffd <= 1'b0;
			cfg_1ffd     <= 2'd0;
			ext_eff7     <= 1'b0;
			page_128k    <= 3'd0;
		end else if (port_wr) begin
			case (port_op)
				zx_bus_pkg::op_page_7ffd: begin
					bank_7ffd <= data[2:0];
					rom_7ffd  <= data[4];
					lock_7ffd <= data[5];
					// Pentagon 1024 borrows the top data bits
					if (is_p1024 && !ext_eff7) begin
						page_128k <= {data[5], data[7:6]};
					end
				end
				zx_bus_pkg::op_page_1ffd: begin
					special_1ffd <= data[0];
					cfg_1ffd     <= data[2:1];
				end
				zx_bus_pkg::op_page_eff7: ext_eff7  <= data[2];
				zx_bus_pkg::op_page_dffd: page_128k <= data[2:0];
				default: ;
			endcase
		end
	end

	// Lock bit only counts in 1024 mode once EFF7 bit 2 is set
	assign page_lock = is_48 | (~is_p1024 & lock_7ffd) | (is_p1024 & ext_eff7 & lock_7ffd);

	assign page_ram     = {page_128k, bank_7ffd};
	assign page_special = special_1ffd;
	assign plus3_cfg    = cfg_1ffd;

	// ROM select
	always_comb begin
		if (is_plus3) begin
			page_rom = {2'b10, cfg_1ffd[1], rom_7ffd};
		end else begin
			page_rom = {is_48, 2'b11, is_48 | rom_7ffd};   // 48K pinned to page 1111
		end
	end

	// The decoder gates EFF7 and DFFD by mode
	high_bank_mode: assert property (@(posedge clk_sys) disable iff (reset)
		!(arch inside {zx_mem_pkg::arch_p1024, zx_mem_pkg::arch_pf1024})
		|-> page_128k == 3'd0);

endmodule

// ==== hw/zx_port_decode.sv ====
module zx_port_decode (
	input  logic                          clk_sys,
	input  logic                          reset,
	input  logic [zx_bus_pkg::addr_w-1:0] addr,
	input  logic                          n_iorq,
	input  logic                          n_wr,
	input  logic                          n_m1,
	input  zx_mem_pkg::arch_t             arch,
	input  logic                          page_lock,
	output zx_bus_pkg::port_op_t          port_op,
	output logic                          port_wr
);

	logic io_wr;
	logic io_wr_d;
	logic is_plus3;
	logic is_p1024;
	logic is_pf1024;
	logic sel_7ffd;
	logic sel_1ffd;
	logic sel_eff7;
	logic sel_dffd;

	assign io_wr = ~n_iorq & ~n_wr & n_m1;   // Not an interrupt ack

	// Previous write level for edge detect
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			io_wr_d <= 1'b0;
		end else begin
			io_wr_d <= io_wr;
		end
	end

	assign port_wr = io_wr & ~io_wr_d;

	assign is_plus3  = (arch == zx_mem_pkg::arch_plus3);
	assign is_p1024  = (arch == zx_mem_pkg::arch_p1024);
	assign is_pf1024 = (arch == zx_mem_pkg::arch_pf1024);

	// Partial decodes as on the real machines
	assign sel_7ffd = ~addr[15] & ~addr[1] & (addr[14] | ~is_plus3) & ~page_lock;
	assign sel_1ffd = is_plus3 & (addr[15:12] == 4'b0001) & ~addr[1] & ~page_lock;
	assign sel_eff7 = is_p1024 & (addr[15:12] == 4'b1110) & ~addr[3];
	assign sel_dffd = is_pf1024 & (addr == zx_bus_pkg::port_profi);

	// ========================================
	// Opcode, first match wins
	always_comb begin
		port_op = zx_bus_pkg::op_none;
		if (sel_7ffd) begin
			port_op = zx_bus_pkg::op_page_7ffd;
		end else if (sel_1ffd) begin
			port_op = zx_bus_pkg::op_page_1ffd;
		end else if (sel_eff7) begin
			port_op = zx_bus_pkg::op_page_eff7;
		end else if (sel_dffd) begin
			port_op = zx_bus_pkg::op_page_dffd;
		end else if (~addr[0]) begin
			port_op = zx_bus_pkg::op_ula_fe;   // Any even port
		end else begin
			case (addr[7:0])
				zx_bus_pkg::port_covox:  port_op = zx_bus_pkg::op_covox;
				zx_bus_pkg::port_sdrv_a: port_op = zx_bus_pkg::op_sdrv_a;
				zx_bus_pkg::port_sdrv_b: port_op = zx_bus_pkg::op_sdrv_b;
				zx_bus_pkg::port_sdrv_c: port_op = zx_bus_pkg::op_sdrv_c;
				zx_bus_pkg::port_sdrv_d: port_op = zx_bus_pkg::op_sdrv_d;
				default:                 port_op = zx_bus_pkg::op_none;
			endcase
		end
	end

	// One pulse per bus write, however long the strobe is held
	single_pulse: assert property (@(posedge clk_sys) disable iff (reset)
		port_wr |=> !port_wr);

endmodule

// ==== hw/zx_sound_ports.sv ====
module zx_sound_ports (
	input  logic                           clk_sys,
	input  logic                           reset,
	input  zx_bus_pkg::port_op_t           port_op,
	input  logic                           port_wr,
	input  logic [zx_bus_pkg::data_w-1:0]  data,
	output logic [2:0]                     border,
	output logic                           ear,
	output logic                           mic,
	output logic [zx_bus_pkg::audio_w-1:0] audio_l,
	output logic [zx_bus_pkg::audio_w-1:0] audio_r
);

	logic [zx_bus_pkg::data_w-1:0] sd_l0;
	logic [zx_bus_pkg::data_w-1:0] sd_l1;
	logic [zx_bus_pkg::data_w-1:0] sd_r0;
	logic [zx_bus_pkg::data_w-1:0] sd_r1;

	// Two samples times 16, ear at 2048, mic at 1024
	function automatic logic [zx_bus_pkg::audio_w-1:0] chan_sum(
		input logic [zx_bus_pkg::data_w-1:0] s0,
		input logic [zx_bus_pkg::data_w-1:0] s1,
		input logic                          e,
		input logic                          m
	);
		localparam int pad = zx_bus_pkg::audio_w - zx_bus_pkg::data_w - 4;
		return {{pad{1'b0}}, s0, 4'd0} + {{pad{1'b0}}, s1, 4'd0} + {2'b00, e, m, 10'd0};
	endfunction

	// Border colour has no reset value
	always_ff @(posedge clk_sys) begin
		if (port_wr && port_op == zx_bus_pkg::op_ula_fe) begin
			border <= data[2:0];
		end
	end

	// ========================================
	// ULA bits and sample latches
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			ear   <= 1'b0;
			mic   <= 1'b0;
			sd_l0 <= '0;
			sd_l1 <= '0;
			sd_r0 <= '0;
			sd_r1 <= '0;
		end else if (port_wr) begin
			case (port_op)
				zx_bus_pkg::op_ula_fe: begin
					ear <= data[4];
					mic <= data[3];
				end
				zx_bus_pkg::op_covox: begin   // Mono, all four at once
					sd_l0 <= data;
					sd_l1 <= data;
					sd_r0 <= data;
					sd_r1 <= data;
				end
				zx_bus_pkg::op_sdrv_a: sd_l0 <= data;
				zx_bus_pkg::op_sdrv_b: sd_l1 <= data;
				zx_bus_pkg::op_sdrv_c: sd_r0 <= data;
				zx_bus_pkg::op_sdrv_d: sd_r1 <= data;
				default: ;
			endcase
		end
	end

	// Mix one cycle behind the latches
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			audio_l <= '0;
			audio_r <= '0;
		end else begin
			audio_l <= chan_sum(sd_l0, sd_l1, ear, mic);
			audio_r <= chan_sum(sd_r0, sd_r1, ear, mic);
		end
	end

endmodule

// ==== project.f ====
hw/zx_bus_pkg.sv
hw/zx_mem_pkg.sv
hw/zx_port_decode.sv
hw/zx_paging.sv
hw/zx_sound_ports.sv
hw/zx_mem_map.sv
hw/zx_host_core.sv
test/zx_checker.sv
test/tb_zx_host_core.sv

// ==== test/tb_zx_host_core.sv ====
module tb_zx_host_core;
	timeunit 1ns;
	timeprecision 100ps;

	typedef enum logic [1:0] {row_reset, row_io_wr, row_mem_wr, row_mem_rd} row_kind_t;

	typedef struct packed {
		row_kind_t                         kind;
		zx_mem_pkg::arch_t                 mode;
		logic [zx_bus_pkg::addr_w-1:0]     addr;
		logic [zx_bus_pkg::data_w-1:0]     data;
		logic                              chk_addr;
		logic [zx_mem_pkg::ram_addr_w-1:0] exp_addr;
		logic                              exp_we;
		logic                              chk_border;
		logic [2:0]                        exp_border;
		logic                              exp_ear;
		logic                              exp_mic;
		logic [zx_bus_pkg::audio_w-1:0]    exp_audio_l;
		logic [zx_bus_pkg::audio_w-1:0]    exp_audio_r;
	} row_t;

	localparam int max_rows = 64;

	logic                              clk_sys;
	logic                              reset;
	zx_mem_pkg::arch_t                 mem_mode;
	logic [zx_bus_pkg::addr_w-1:0]     addr;
	logic [zx_bus_pkg::data_w-1:0]     data;
	logic                              n_mreq;
	logic                              n_iorq;
	logic                              n_rd;
	logic                              n_wr;
	logic                              n_m1;
	logic [zx_mem_pkg::ram_addr_w-1:0] ram_addr;
	logic                              ram_we;
	logic [2:0]                        border;
	logic                              ear;
	logic                              mic;
	logic [zx_bus_pkg::audio_w-1:0]    audio_l;
	logic [zx_bus_pkg::audio_w-1:0]    audio_r;

	row_t table_rows [max_rows];
	row_t cur;            // Row being applied
	int   n_rows;
	int   n_resets;
	int   row_idx;
	int   cycles;
	int   cycle_limit;
	int   n_pass;
	int   n_fail;
	logic check;

	// Expected sound side while the table is built
	logic                           snd_known;
	logic [2:0]                     snd_border;
	logic                           snd_ear;
	logic                           snd_mic;
	logic [zx_bus_pkg::audio_w-1:0] snd_l;
	logic [zx_bus_pkg::audio_w-1:0] snd_r;

	zx_host_core zx_host_core_i (
		.clk_sys (clk_sys),
		.reset   (reset),
		.mem_mode(mem_mode),
		.addr    (addr),
		.data    (data),
		.n_mreq  (n_mreq),
		.n_iorq  (n_iorq),
		.n_rd    (n_rd),
		.n_wr    (n_wr),
		.n_m1    (n_m1),
		.ram_addr(ram_addr),
		.ram_we  (ram_we),
		.border  (border),
		.ear     (ear),
		.mic     (mic),
		.audio_l (audio_l),
		.audio_r (audio_r)
	);

	zx_checker zx_checker_i (
		.clk_sys    (clk_sys),
		.check      (check),
		.row_idx    (row_idx),
		.chk_addr   (cur.chk_addr),
		.chk_border (cur.chk_border),
		.exp_addr   (cur.exp_addr),
		.exp_we     (cur.exp_we),
		.exp_border (cur.exp_border),
		.exp_ear    (cur.exp_ear),
		.exp_mic    (cur.exp_mic),
		.exp_audio_l(cur.exp_audio_l),
		.exp_audio_r(cur.exp_audio_r),
		.ram_addr   (ram_addr),
		.ram_we     (ram_we),
		.border     (border),
		.ear        (ear),
		.mic        (mic),
		.audio_l    (audio_l),
		.audio_r    (audio_r),
		.n_pass     (n_pass),
		.n_fail     (n_fail)
	);

	initial clk_sys = 1'b0;
	always #2 clk_sys = ~clk_sys;

	// Run length guard
	always @(posedge clk_sys) begin
		cycles <= cycles + 1;
		if (cycle_limit > 0 && cycles >= cycle_limit) begin
			$display("Run timed out after %0d cycles, the stimulus loop never finished", cycles);
			$display("TEST FAILED");
			$finish;
		end
	end

	// ========================================
	// Table building
	task automatic push_row(input row_kind_t kind, input zx_mem_pkg::arch_t mode,
		input logic [15:0] a, input logic [7:0] d, input logic chk_a,
		input logic [23:0] ea, input logic ewe);
		row_t r;
		r.kind        = kind;
		r.mode        = mode;
		r.addr        = a;
		r.data        = d;
		r.chk_addr    = chk_a;
		r.exp_addr    = ea;
		r.exp_we      = ewe;
		r.chk_border  = snd_known;
		r.exp_border  = snd_border;
		r.exp_ear     = snd_ear;
		r.exp_mic     = snd_mic;
		r.exp_audio_l = snd_l;
		r.exp_audio_r = snd_r;
		table_rows[n_rows] = r;
		n_rows = n_rows + 1;
	endtask

	task automatic add_reset(input zx_mem_pkg::arch_t mode);
		snd_ear  = 1'b0;   // Border survives reset
		snd_mic  = 1'b0;
		snd_l    = '0;
		snd_r    = '0;
		n_resets = n_resets + 1;
		push_row(row_reset, mode, 16'h0000, 8'h00, 1'b0, '0, 1'b0);
	endtask

	task automatic add_io_write(input logic [15:0] a, input logic [7:0] d);
		push_row(row_io_wr, zx_mem_pkg::arch_128, a, d, 1'b0, '0, 1'b0);
	endtask

	task automatic add_mem_read(input logic [15:0] a, input logic [23:0] ea);
		push_row(row_mem_rd, zx_mem_pkg::arch_128, a, 8'h00, 1'b1, ea, 1'b0);
	endtask

	task automatic add_mem_write(input logic [15:0] a, input logic [23:0] ea, input logic ewe);
		push_row(row_mem_wr, zx_mem_pkg::arch_128, a, 8'hA5, 1'b1, ea, ewe);
	endtask

	task automatic expect_sound(input logic [2:0] b, input logic e, input logic m,
		input int l, input int r);
		snd_known  = 1'b1;
		snd_border = b;
		snd_ear    = e;
		snd_mic    = m;
		snd_l      = l[zx_bus_pkg::audio_w-1:0];
		snd_r      = r[zx_bus_pkg::audio_w-1:0];
	endtask

	// SDRAM address is bank * 4000h plus the window offset
	task automatic build_table();
		snd_known = 1'b0;
		snd_border = 3'd0;
		// 128K paging, ROM page 0110 at 158000
		add_reset(zx_mem_pkg::arch_128);
		add_mem_read(16'h0000, 24'h158000);
		add_mem_read(16'hC000, 24'h000000);
		add_io_write(16'h7FFD, 8'h13);
		add_mem_read(16'hC000, 24'h00C000);
		add_mem_read(16'h0000, 24'h15C000);   // ROM page 0111
		add_mem_write(16'h4000, 24'h014000, 1'b1);
		add_mem_write(16'hC123, 24'h00C123, 1'b1);
		add_mem_write(16'h0000, 24'h15C000, 1'b0);
		add_mem_read(16'h8000, 24'h008000);
		// Lock until the next reset
		add_io_write(16'h7FFD, 8'h24);
		add_mem_read(16'hC000, 24'h010000);
		add_io_write(16'h7FFD, 8'h01);
		add_mem_read(16'hC000, 24'h010000);
		add_mem_read(16'h0000, 24'h158000);
		add_reset(zx_mem_pkg::arch_128);
		add_io_write(16'h7FFD, 8'h01);
		add_mem_read(16'hC000, 24'h004000);
		// 48K ignores 7FFD, ROM page 1111
		add_reset(zx_mem_pkg::arch_48);
		add_io_write(16'h7FFD, 8'h03);
		add_mem_read(16'hC000, 24'h000000);
		add_mem_read(16'h0000, 24'h17C000);
		// ========================================
		// +3 special modes
		add_reset(zx_mem_pkg::arch_plus3);
		add_mem_read(16'h0000, 24'h160000);   // ROM page 1000
		add_io_write(16'h1FFD, 8'h01);
		add_mem_write(16'h0000, 24'h000000, 1'b1);
		add_mem_read(16'hC000, 24'h00C000);
		add_io_write(16'h1FFD, 8'h03);
		add_mem_read(16'h0000, 24'h010000);
		add_mem_read(16'hC000, 24'h01C000);
		add_io_write(16'h1FFD, 8'h05);
		add_mem_read(16'h8000, 24'h018000);
		add_mem_read(16'hC000, 24'h00C000);
		add_io_write(16'h1FFD, 8'h07);
		add_mem_read(16'h4000, 24'h01C000);
		add_mem_write(16'h0000, 24'h010000, 1'b1);
		add_io_write(16'h1FFD, 8'h04);        // Back to ROM, page 1010
		add_mem_read(16'h0000, 24'h168000);
		add_mem_write(16'h0000, 24'h168000, 1'b0);
		// Pentagon 1024
		add_reset(zx_mem_pkg::arch_p1024);
		add_io_write(16'h7FFD, 8'hE1);
		add_mem_read(16'hC000, 24'h0E4000);   // Bank 39h
		add_io_write(16'h7FFD, 8'hC1);
		add_mem_read(16'hC000, 24'h064000);   // Bank 19h
		add_io_write(16'hEFF7, 8'h04);
		add_io_write(16'h7FFD, 8'h07);
		add_mem_read(16'hC000, 24'h07C000);   // High bits kept, bank 1Fh
		add_reset(zx_mem_pkg::arch_pf1024);
		add_io_write(16'hDFFD, 8'h05);
		add_mem_read(16'hC000, 24'h0A0000);
		add_io_write(16'h7FFD, 8'h03);
		add_mem_read(16'hC000, 24'h0AC000);
		// ========================================
		// ULA and sample ports
		add_reset(zx_mem_pkg::arch_128);
		expect_sound(3'd5, 1'b1, 1'b1, 3072, 3072);
		add_io_write(16'h00FE, 8'h1D);
		expect_sound(3'd5, 1'b1, 1'b1, 3584, 3584);   // 256 + 256 + 3072
		add_io_write(16'h00FB, 8'h10);
		expect_sound(3'd5, 1'b1, 1'b1, 3840, 3584);
		add_io_write(16'h000F, 8'h20);
		expect_sound(3'd5, 1'b1, 1'b1, 3840, 4352);
		add_io_write(16'h005F, 8'h40);
		expect_sound(3'd5, 1'b1, 1'b1, 7664, 4352);   // 512 + 4080 + 3072
		add_io_write(16'h001F, 8'hFF);
		expect_sound(3'd5, 1'b1, 1'b1, 7664, 4096);
		add_io_write(16'h004F, 8'h00);
		add_mem_read(16'h4000, 24'h014000);
		expect_sound(3'd2, 1'b0, 1'b0, 4592, 1024);
		add_io_write(16'h00FE, 8'h02);
	endtask

	// ========================================
	// Row application
	task automatic bus_idle();
		n_mreq = 1'b1;
		n_iorq = 1'b1;
		n_rd   = 1'b1;
		n_wr   = 1'b1;
		n_m1   = 1'b1;
	endtask

	task automatic hold_cycles(input int n);
		for (int c = 0; c < n; c++) begin
			check = (c == n - 1);
			@(posedge clk_sys);
			#1;
		end
		check = 1'b0;
	endtask

	task automatic apply_row(input int idx);
		row_t r;
		r       = table_rows[idx];
		row_idx = idx;
		cur     = r;
		addr    = r.addr;
		data    = r.data;
		bus_idle();
		case (r.kind)
			row_reset: begin
				reset    = 1'b1;
				mem_mode = r.mode;
				hold_cycles(8);
				reset    = 1'b0;
			end
			row_io_wr: begin
				n_iorq = 1'b0;
				n_wr   = 1'b0;
				hold_cycles(3);
				bus_idle();   // One released cycle
				@(posedge clk_sys);
				#1;
			end
			row_mem_wr: begin
				n_mreq = 1'b0;
				n_wr   = 1'b0;
				hold_cycles(2);
			end
			default: begin
				n_mreq = 1'b0;
				n_rd   = 1'b0;
				hold_cycles(2);
			end
		endcase
	endtask

	initial begin
		reset       = 1'b1;
		mem_mode    = zx_mem_pkg::arch_128;
		addr        = '0;
		data        = '0;
		check       = 1'b0;
		row_idx     = 0;
		cur         = '0;
		cycles      = 0;
		cycle_limit = 0;
		n_rows      = 0;
		n_resets    = 0;
		bus_idle();
		build_table();
		cycle_limit = n_rows * 8 + n_resets * 8 + 100;

		repeat (8) @(posedge clk_sys);
		#1;
		reset = 1'b0;

		for (int i = 0; i < n_rows; i++) begin
			apply_row(i);
		end
		bus_idle();
		repeat (2) @(posedge clk_sys);

		$display("Rows: %0d, passed: %0d, failed: %0d", n_rows, n_pass, n_fail);
		if (n_fail == 0 && n_pass == n_rows) begin
			$display("TEST OK");
		end else begin
			if (n_pass + n_fail != n_rows)
				$display("Only %0d of %0d rows were checked", n_pass + n_fail, n_rows);
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

// ==== test/zx_checker.sv ====
module zx_checker (
	input  logic                              clk_sys,
	input  logic                              check,      // Last held cycle of a row
	input  int                                row_idx,
	input  logic                              chk_addr,
	input  logic                              chk_border,
	input  logic [zx_mem_pkg::ram_addr_w-1:0] exp_addr,
	input  logic                              exp_we,
	input  logic [2:0]                        exp_border,
	input  logic                              exp_ear,
	input  logic                              exp_mic,
	input  logic [zx_bus_pkg::audio_w-1:0]    exp_audio_l,
	input  logic [zx_bus_pkg::audio_w-1:0]    exp_audio_r,
	input  logic [zx_mem_pkg::ram_addr_w-1:0] ram_addr,
	input  logic                              ram_we,
	input  logic [2:0]                        border,
	input  logic                              ear,
	input  logic                              mic,
	input  logic [zx_bus_pkg::audio_w-1:0]    audio_l,
	input  logic [zx_bus_pkg::audio_w-1:0]    audio_r,
	output int                                n_pass,
	output int                                n_fail
);
	timeunit 1ns;
	timeprecision 100ps;

	string mismatch;   // Every wrong field of one row

	initial begin
		n_pass = 0;
		n_fail = 0;
	end

	// ========================================
	// Sampled mid-cycle with all inputs settled
	always @(negedge clk_sys) begin
		if (check) begin
			mismatch = "";
			if (chk_addr && ram_addr !== exp_addr)
				mismatch = {mismatch, $sformatf(" ram_addr %h exp %h", ram_addr, exp_addr)};
			if (ram_we !== exp_we)
				mismatch = {mismatch, $sformatf(" ram_we %b exp %b", ram_we, exp_we)};
			if (chk_border && border !== exp_border)
				mismatch = {mismatch, $sformatf(" border %0d exp %0d", border, exp_border)};
			if (ear !== exp_ear || mic !== exp_mic)
				mismatch = {mismatch, $sformatf(" ear/mic %b%b exp %b%b", ear, mic,
					exp_ear, exp_mic)};
			if (audio_l !== exp_audio_l)
				mismatch = {mismatch, $sformatf(" audio_l %0d exp %0d", audio_l, exp_audio_l)};
			if (audio_r !== exp_audio_r)
				mismatch = {mismatch, $sformatf(" audio_r %0d exp %0d", audio_r, exp_audio_r)};

			if (mismatch == "") begin
				n_pass = n_pass + 1;
				$display("[PASS] row %0d", row_idx);
			end else begin
				n_fail = n_fail + 1;
				$display("[FAIL] %0d ns row %0d:%s", $time, row_idx, mismatch);
			end
		end
	end

endmodule
